// File: compile.f
+incdir+source
source/isa_pkg.sv
source/stage_pkg.sv
source/alu.sv
source/branch_unit.sv
source/mul_sequencer.sv
source/execute_pipe_reg.sv
source/execute_top.sv
tb/execute_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f compile.f --top-module execute_tb -o execute_tb \
    && ./obj_dir/execute_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }

cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

// File: tb/execute_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage testbench
// Streams random ALU, branch, jump, multiply and memory records through
// the stage and checks results, redirects and handshake timing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "core_macros.svh"

module execute_tb
    import isa_pkg::*;
    import stage_pkg::*;
;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        mm_t   rec;
        logic  taken;
        word_t target;
    } expect_t;

    logic  sink;
    logic  rst_n;
    logic  in_valid;
    logic  in_ready;
    ex_t   in_data;
    logic  out_valid;
    logic  out_ready;
    mm_t   out_data;
    logic  branch;
    word_t target;
    word_t bypass;

    int    seed = 32'hdfd75289;
    int    rdy_seed = 32'hdfd75289 ^ 32'h2c1b3a45;
    logic  bp_en = 1'b0;
    logic  mul_pending = 1'b0;
    int    errors = 0;
    int    timeouts = 0;
    int    received = 0;
    mm_t   exp_q[$];

    execute_top DUT (
        .sink      (sink),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .branch    (branch),
        .target    (target),
        .bypass    (bypass)
    );

    initial begin
        sink = 1'b0;
        forever #50 sink = ~sink;
    end

    // Expected output record and redirect for one input record.
    function automatic expect_t predict(input ex_t ex);
        expect_t    e;
        word_t      a;
        word_t      b;
        word_t      alu_val;
        logic [4:0] sh;
        logic       taken;
        a = ex.data.op1;
        b = ex.data.op2;
        sh = b[4:0];
        case (ex.ctrl.fn)
            ADD:     alu_val = a + b;
            SUB:     alu_val = a - b;
            SLL:     alu_val = a << sh;
            SLT:     alu_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    alu_val = (a < b) ? 32'd1 : 32'd0;
            XOR:     alu_val = a ^ b;
            SRL:     alu_val = a >> sh;
            SRA:     alu_val = word_t'($signed(a) >>> sh);
            OR:      alu_val = a | b;
            AND:     alu_val = a & b;
            default: alu_val = '0;
        endcase
        taken = 1'b0;
        if (ex.ctrl.op == OP_JUMP) begin
            taken = 1'b1;
        end else if (ex.ctrl.op == OP_BRANCH) begin
            case (ex.ctrl.br)
                BEQ:     taken = ex.data.rs1 == ex.data.rs2;
                BNE:     taken = ex.data.rs1 != ex.data.rs2;
                BLT:     taken = $signed(ex.data.rs1) < $signed(ex.data.rs2);
                BGE:     taken = $signed(ex.data.rs1) >= $signed(ex.data.rs2);
                BLTU:    taken = ex.data.rs1 < ex.data.rs2;
                BGEU:    taken = ex.data.rs1 >= ex.data.rs2;
                default: taken = 1'b0;
            endcase
        end
        e.rec.op = ex.ctrl.op;
        e.rec.br = ex.ctrl.br;
        e.rec.rd = ex.data.rd;
        e.rec.rs2 = ex.data.rs2;
        if (ex.ctrl.op == OP_MUL) begin
            e.rec.result = word_t'(a * b);
        end else if (ex.ctrl.op == OP_JUMP) begin
            e.rec.result = ex.data.pc + 32'd4;
        end else begin
            e.rec.result = alu_val;
        end
        e.taken = taken;
        e.target = taken ? a + b : ex.data.pc + 32'd4;
        return e;
    endfunction

    // Random record of one operation class.
    task automatic make_record(input op_t op, output ex_t rec);
        int unsigned sel;
        rec = '0;
        rec.ctrl.op = op;
        sel = $unsigned($random(seed)) % 10;
        rec.ctrl.fn = alu_fn_t'(sel[3:0]);
        sel = $unsigned($random(seed)) % 6;
        rec.ctrl.br = br_t'(sel[2:0]);
        rec.data.pc = word_t'($random(seed)) & 32'hffff_fffc;
        rec.data.rs1 = $random(seed);
        rec.data.rs2 = $random(seed);
        // Equal operands and opposite sign bits now and then.
        sel = $unsigned($random(seed)) % 4;
        if (sel == 0) begin
            rec.data.rs2 = rec.data.rs1;
        end else if (sel == 1) begin
            rec.data.rs2[31] = ~rec.data.rs1[31];
        end
        rec.data.op1 = $random(seed);
        rec.data.op2 = $random(seed);
        if (op == OP_BRANCH || op == OP_JUMP) begin
            rec.data.op1 = rec.data.pc;
        end
        sel = $unsigned($random(seed)) % 32;
        rec.data.rd = reg_addr_t'(sel[4:0]);
    endtask

    // In_ready must stay low until the product shows up.
    task automatic check_mul_latency();
        int   k;
        logic seen;
        k = 0;
        seen = 1'b0;
        @(negedge sink);
        in_valid = 1'b0;
        while (!seen && k <= WAIT_LIMIT) begin
            #25;
            if (out_valid) begin
                seen = 1'b1;
            end else begin
                if (in_ready) begin
                    $display("** Error at %0t: in_ready high during multiply", $time);
                    errors++;
                end
                k++;
                @(negedge sink);
            end
        end
        mul_pending = 1'b0;
        if (!seen) begin
            $display("Timeout: multiply result never appeared at the output");
            timeouts++;
        end else if (k != `MUL_STEPS + 1) begin
            $display("** Error at %0t: multiply took %0d cycles, expected %0d",
                     $time, k, `MUL_STEPS + 1);
            errors++;
        end
    endtask

    // Presents one record and holds it until the DUT takes it.
    task automatic send_record(input ex_t rec);
        int      waited;
        logic    accepted;
        expect_t e;
        e = predict(rec);
        waited = 0;
        accepted = 1'b0;
        @(negedge sink);
        in_valid = 1'b1;
        in_data = rec;
        while (!accepted && waited < WAIT_LIMIT) begin
            #25;
            if (in_ready) begin
                accepted = 1'b1;
                exp_q.push_back(e.rec);
                if (rec.ctrl.op == OP_MUL) begin
                    mul_pending = 1'b1;
                end
            end else begin
                @(negedge sink);
                waited++;
            end
        end
        if (!accepted) begin
            $display("Timeout: input record was never accepted");
            timeouts++;
            @(negedge sink);
            in_valid = 1'b0;
        end else if (rec.ctrl.op == OP_MUL) begin
            check_mul_latency();
        end
    endtask

    initial begin : drive_out_ready
        out_ready = 1'b1;
        forever begin
            @(negedge sink);
            if (bp_en) begin
                out_ready = ($unsigned($random(rdy_seed)) % 3) != 0;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // Samples a quarter period before each rising edge.
    initial begin : compare_outputs
        expect_t e;
        mm_t     exp_rec;
        mm_t     held;
        logic    stalled;
        stalled = 1'b0;
        held = '0;
        forever begin
            @(negedge sink);
            #25;
            if (rst_n) begin
                if (in_valid) begin
                    e = predict(in_data);
                    if (branch !== e.taken || target !== e.target) begin
                        $display("** Error at %0t: branch %0b target %h, expected %0b %h",
                                 $time, branch, target, e.taken, e.target);
                        errors++;
                    end
                    if (in_data.ctrl.op != OP_MUL && bypass !== e.rec.result) begin
                        $display("** Error at %0t: bypass %h, expected %h",
                                 $time, bypass, e.rec.result);
                        errors++;
                    end
                end else if (branch !== 1'b0) begin
                    $display("** Error at %0t: branch high without a valid record", $time);
                    errors++;
                end
                // Outside a multiply the input opens whenever the output can move.
                if (!mul_pending && in_ready !== (!out_valid || out_ready)) begin
                    $display("** Error at %0t: in_ready %0b with out_valid %0b out_ready %0b",
                             $time, in_ready, out_valid, out_ready);
                    errors++;
                end
                if (stalled && (out_valid !== 1'b1 || out_data !== held)) begin
                    $display("** Error at %0t: output record changed while stalled", $time);
                    errors++;
                end
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("Output record appeared that was never sent in");
                        errors++;
                    end else begin
                        exp_rec = exp_q.pop_front();
                        received++;
                        if (out_data.result !== exp_rec.result) begin
                            $display("** Error at %0t: result %h, expected %h",
                                     $time, out_data.result, exp_rec.result);
                            errors++;
                        end
                        if (out_data.op !== exp_rec.op || out_data.br !== exp_rec.br
                                || out_data.rd !== exp_rec.rd
                                || out_data.rs2 !== exp_rec.rs2) begin
                            $display("** Error at %0t: op/br/rd/rs2 fields do not match",
                                     $time);
                            errors++;
                        end
                    end
                end
                stalled = out_valid && !out_ready;
                held = out_data;
            end
        end
    end

    initial begin : run_test
        ex_t         rec;
        int          waited;
        int unsigned sel;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        repeat (10) @(negedge sink);
        rst_n = 1'b1;
        // Idle state straight after reset.
        @(negedge sink);
        #25;
        if (out_valid !== 1'b0 || branch !== 1'b0 || in_ready !== 1'b1) begin
            $display("** Error at %0t: idle outputs wrong after reset", $time);
            errors++;
        end
        for (int i = 0; i < 60; i++) begin
            make_record(OP_ALU, rec);
            send_record(rec);
        end
        for (int i = 0; i < 60; i++) begin
            make_record(OP_BRANCH, rec);
            send_record(rec);
        end
        for (int i = 0; i < 6; i++) begin
            make_record(OP_JUMP, rec);
            send_record(rec);
        end
        for (int i = 0; i < 8; i++) begin
            make_record(OP_MUL, rec);
            send_record(rec);
        end
        // Mixed traffic under random back-pressure.
        bp_en = 1'b1;
        for (int i = 0; i < 80; i++) begin
            sel = $unsigned($random(seed)) % 6;
            make_record(op_t'(sel[2:0]), rec);
            send_record(rec);
        end
        bp_en = 1'b0;
        @(negedge sink);
        in_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge sink);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d records never left the stage", exp_q.size());
            timeouts++;
        end
        repeat (3) @(negedge sink);
        $display("Run complete: %0d records compared, %0d errors, %0d timeouts",
                 received, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: source/execute_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage
// ALU, branch unit, multiplier and output register of the pipeline.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module execute_top
    import isa_pkg::*;
    import stage_pkg::*;
(
    input  logic  sink,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  ex_t   in_data,
    output logic  out_valid,
    input  logic  out_ready,
    output mm_t   out_data,
    output logic  branch,
    output word_t target,
    output word_t bypass
);

    word_t alu_out;
    word_t mul_product;
    logic  mul_start;
    logic  mul_busy;
    logic  mul_done;

    alu u_alu (
        .fn  (in_data.ctrl.fn),
        .op1 (in_data.data.op1),
        .op2 (in_data.data.op2),
        .out (alu_out)
    );

    branch_unit u_branch_unit (
        .valid  (in_valid),
        .ex     (in_data),
        .branch (branch),
        .target (target)
    );

    mul_sequencer u_mul_sequencer (
        .sink         (sink),
        .rst_n        (rst_n),
        .start        (mul_start),
        .multiplicand (in_data.data.op1),
        .multiplier   (in_data.data.op2),
        .busy         (mul_busy),
        .done         (mul_done),
        .product      (mul_product)
    );

    execute_pipe_reg u_execute_pipe_reg (
        .sink        (sink),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .alu_out     (alu_out),
        .mul_busy    (mul_busy),
        .mul_done    (mul_done),
        .mul_product (mul_product),
        .mul_start   (mul_start),
        .bypass      (bypass),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data)
    );

endmodule

// File: source/execute_pipe_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute pipeline register
// Selects the result, holds the memory stage record with a valid/ready
// handshake and parks multiply records until the product is ready.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module execute_pipe_reg
    import isa_pkg::*;
    import stage_pkg::*;
(
    input  logic  sink,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  ex_t   in_data,
    input  word_t alu_out,
    input  logic  mul_busy,
    input  logic  mul_done,
    input  word_t mul_product,
    output logic  mul_start,
    output word_t bypass,
    output logic  out_valid,
    input  logic  out_ready,
    output mm_t   out_data
);

    logic  accept;
    logic  is_mul;
    logic  load_now;
    word_t result;
    mm_t   next_rec;
    mm_t   pend;

    // Stall while the output is blocked or a product is in progress.
    assign in_ready = (~out_valid | out_ready) & ~mul_busy;

    assign accept    = in_valid & in_ready;
    assign is_mul    = in_data.ctrl.op == OP_MUL;
    assign mul_start = accept & is_mul;
    assign load_now  = accept & ~is_mul;

    // Jumps write the link address.
    always_comb begin
        if (in_data.ctrl.op == OP_JUMP) begin
            result = in_data.data.pc + word_t'(4);
        end else begin
            result = alu_out;
        end
    end

    assign bypass = result;

    always_comb begin
        next_rec.op     = in_data.ctrl.op;
        next_rec.br     = in_data.ctrl.br;
        next_rec.rd     = in_data.data.rd;
        next_rec.result = result;
        next_rec.rs2    = in_data.data.rs2;
    end

    always_ff @(posedge sink) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load_now || mul_done) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Record payload with the product in place of the parked result.
    always_ff @(posedge sink) begin
        if (mul_start) begin
            pend <= next_rec;
        end
        if (load_now) begin
            out_data <= next_rec;
        end else if (mul_done) begin
            out_data        <= pend;
            out_data.result <= mul_product;
        end
    end

endmodule

// File: source/mul_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiplier sequencer
// Iterative shift-add multiplier, one multiplier bit per cycle,
// giving the low word of the product.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

`include "core_macros.svh"

module mul_sequencer
    import isa_pkg::*;
(
    input  logic  sink,
    input  logic  rst_n,
    input  logic  start,
    input  word_t multiplicand,
    input  word_t multiplier,
    output logic  busy,
    output logic  done,
    output word_t product
);

    localparam int CNT_W = $clog2(`MUL_STEPS);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] count;
    word_t            acc;
    word_t            mcand;
    word_t            mplier;

    // Sequencer FSM and step counter.
    always_ff @(posedge sink) begin
        if (!rst_n) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        count <= '0;
                    end
                end
                RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(`MUL_STEPS - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Shift-add datapath.
    always_ff @(posedge sink) begin
        if (state == IDLE && start) begin
            acc    <= '0;
            mcand  <= multiplicand;
            mplier <= multiplier;
        end else if (state == RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign busy    = state != IDLE;
    assign done    = state == DONE;
    assign product = acc;

endmodule

// File: source/branch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch unit
// Compares the register values, decides taken branches and jumps,
// and computes the next fetch target.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module branch_unit
    import isa_pkg::*;
    import stage_pkg::*;
(
    input  logic  valid,
    input  ex_t   ex,
    output logic  branch,
    output word_t target
);

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    // Comparators on the register values.
    assign eq  = ex.data.rs1 == ex.data.rs2;
    assign lt  = $signed(ex.data.rs1) < $signed(ex.data.rs2);
    assign ltu = ex.data.rs1 < ex.data.rs2;

    always_comb begin
        taken = 1'b0;
        if (ex.ctrl.op == OP_JUMP) begin
            taken = 1'b1;
        end else if (ex.ctrl.op == OP_BRANCH) begin
            case (ex.ctrl.br)
                BEQ:     taken = eq;
                BNE:     taken = ~eq;
                BLT:     taken = lt;
                BGE:     taken = ~lt;
                BLTU:    taken = ltu;
                BGEU:    taken = ~ltu;
                default: taken = 1'b0;
            endcase
        end
    end

    // Only a valid record redirects fetch.
    assign branch = valid & taken;

    assign target = taken ? ex.data.op1 + ex.data.op2 : ex.data.pc + word_t'(4);

endmodule

// File: source/alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU
// Combinational RV32I register and immediate functions.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module alu
    import isa_pkg::*;
(
    input  alu_fn_t fn,
    input  word_t   op1,
    input  word_t   op2,
    output word_t   out
);

    localparam int SHAMT_W = $clog2($bits(word_t));

    logic [SHAMT_W-1:0] shamt;

    // Shift amount from the low bits of op2.
    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        case (fn)
            ADD: begin
                out = op1 + op2;
            end
            SUB: begin
                out = op1 - op2;
            end
            SLL: begin
                out = op1 << shamt;
            end
            SLT: begin
                out = word_t'($signed(op1) < $signed(op2));
            end
            SLTU: begin
                out = word_t'(op1 < op2);
            end
            XOR: begin
                out = op1 ^ op2;
            end
            SRL: begin
                out = op1 >> shamt;
            end
            // Arithmetic shift keeps the sign bit.
            SRA: begin
                out = $signed(op1) >>> shamt;
            end
            OR: begin
                out = op1 | op2;
            end
            AND: begin
                out = op1 & op2;
            end
            default: begin
                out = '0;
            end
        endcase
    end

endmodule

// File: source/stage_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage package
// Payload records passed from decode into execute and from execute
// on to the memory stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stage_pkg;
    import isa_pkg::*;

    // Control part of the execute record.
    typedef struct packed {
        op_t     op;
        br_t     br;
        alu_fn_t fn;
    } ex_ctrl_t;

    // Register values plus ALU operands after immediate selection.
    typedef struct packed {
        word_t     pc;
        word_t     rs1;
        word_t     rs2;
        word_t     op1;
        word_t     op2;
        reg_addr_t rd;
    } ex_data_t;

    // Execute input record.
    typedef struct packed {
        ex_ctrl_t ctrl;
        ex_data_t data;
    } ex_t;

    // Memory stage record with rs2 as the store data.
    typedef struct packed {
        op_t       op;
        br_t       br;
        reg_addr_t rd;
        word_t     result;
        word_t     rs2;
    } mm_t;

endpackage

// File: source/isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ISA package
// Word and register index types, operation classes, branch conditions
// and ALU function codes of the integer core.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "core_macros.svh"

package isa_pkg;

    // Operands, pc, results and targets.
    typedef logic [`XLEN-1:0] word_t;

    // Destination register index.
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Operation class of a decoded instruction.
    typedef enum logic [2:0] {
        OP_ALU,
        OP_MUL,
        OP_BRANCH,
        OP_JUMP,
        OP_LOAD,
        OP_STORE
    } op_t;

    // Branch condition comparing rs1 with rs2.
    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } br_t;

    // ALU function.
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_fn_t;

endpackage

// File: source/core_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core macros
// Word width, register address width and multiplier iteration count
// shared by the ISA package and the multiplier.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data word width in bits.
`define XLEN 32

// Register file index width.
`define REG_ADDR_W 5

// One shift-add step per multiplier bit.
`define MUL_STEPS `XLEN

`endif
